// ==== hw/lock_pkg.sv ====
`default_nettype none

package lock_pkg;

    // Code and display geometry
    localparam int CODE_DIGITS    = 8;
    localparam int NUM_USER_CODES = 4;
    localparam int DISPLAY_DIGITS = 6;

    // Attempt limit and times, in clock cycles (scaled down for simulation)
    localparam int MAX_ATTEMPTS     = 5;
    localparam int DEBOUNCE_CYCLES  = 4;
    localparam int AUTO_LOCK_CYCLES = 20;
    localparam int BLOCK_CYCLES     = 40;

    // One timer serves both the auto-lock and the lockout
    localparam int TIMER_MAX = (BLOCK_CYCLES > AUTO_LOCK_CYCLES) ? BLOCK_CYCLES
                                                                 : AUTO_LOCK_CYCLES;

    typedef logic [3:0]                     digit_t;
    typedef logic [CODE_DIGITS*4-1:0]       code_t;   // Digit 0 is the last key pressed
    typedef logic [2:0]                     attempts_t;
    typedef logic [$clog2(TIMER_MAX)-1:0]   timer_t;
    typedef logic [$clog2(DEBOUNCE_CYCLES+1)-1:0] debounce_cnt_t;
    typedef logic [$clog2(NUM_USER_CODES)-1:0]    slot_idx_t;

    localparam digit_t DIGIT_ERROR   = 4'hA;
    localparam digit_t DIGIT_BLANK   = 4'hB;  // Also fills unused key positions
    localparam digit_t DIGIT_TIMEOUT = 4'hE;

    // Digit 0 is the rightmost position and gets the first error mark
    typedef struct packed {
        digit_t digit5;
        digit_t digit4;
        digit_t digit3;
        digit_t digit2;
        digit_t digit1;
        digit_t digit0;
    } display_t;

    typedef struct packed {
        code_t [NUM_USER_CODES-1:0] slots;
    } user_codes_t;

    // Room left for further keypad fields
    typedef struct packed {
        code_t code;
    } keypad_req_t;

endpackage

`default_nettype wire

// ==== hw/button_debouncer.sv ====
`timescale 1ns/1ns
`default_nettype none

module button_debouncer import lock_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic button,
    output logic press
);

    localparam debounce_cnt_t HOLD_LAST = debounce_cnt_t'(DEBOUNCE_CYCLES - 1);

    debounce_cnt_t hold_cnt;  // Saturates at HOLD_LAST
    logic          fired;     // Pulse already given for this hold

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hold_cnt <= '0;
            fired    <= 1'b0;
            press    <= 1'b0;
        end else if (!button) begin
            // Release starts over
            hold_cnt <= '0;
            fired    <= 1'b0;
            press    <= 1'b0;
        end else begin
            if (hold_cnt != HOLD_LAST) begin
                hold_cnt <= hold_cnt + 1'b1;
            end
            press <= (hold_cnt == HOLD_LAST) && !fired;
            if (hold_cnt == HOLD_LAST) begin
                fired <= 1'b1;
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        press |=> !press)
        else $error("button_debouncer: press on two consecutive cycles");

endmodule

`default_nettype wire

// ==== hw/code_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

module code_checker import lock_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        check_valid,
    input  code_t       check_code,
    input  user_codes_t user_codes,
    output logic        result_valid,
    output logic        result_match
);

    localparam code_t BLANK_CODE = {CODE_DIGITS{DIGIT_BLANK}};

    logic      busy;
    slot_idx_t slot_idx;
    logic      match_acc;  // OR of all slots compared so far
    code_t     code_q;
    code_t     slot_code;
    logic      slot_hit;
    logic      accept;

    assign accept    = check_valid && !busy;
    assign slot_code = user_codes.slots[slot_idx];

    // An empty slot must not open the door
    assign slot_hit = (slot_code == code_q) && (slot_code != BLANK_CODE);

    // Entry held for the whole scan
    always_ff @(posedge clk) begin
        if (accept) begin
            code_q <= check_code;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy         <= 1'b0;
            slot_idx     <= '0;
            match_acc    <= 1'b0;
            result_valid <= 1'b0;
            result_match <= 1'b0;
        end else begin
            result_valid <= 1'b0;
            if (accept) begin
                busy      <= 1'b1;
                slot_idx  <= '0;
                match_acc <= 1'b0;
            end else if (busy) begin
                match_acc <= match_acc | slot_hit;
                if (slot_idx == slot_idx_t'(NUM_USER_CODES - 1)) begin
                    // Last slot compared, report
                    busy         <= 1'b0;
                    result_valid <= 1'b1;
                    result_match <= match_acc | slot_hit;
                end else begin
                    slot_idx <= slot_idx + 1'b1;
                end
            end
        end
    end

    // The FSM waits for the result before it sends another entry
    assert property (@(posedge clk) disable iff (rst)
        !(check_valid && busy))
        else $error("code_checker: request while busy");

    assert property (@(posedge clk) disable iff (rst)
        result_valid |=> !result_valid)
        else $error("code_checker: result_valid longer than one cycle");

endmodule

`default_nettype wire

// ==== hw/lock_fsm.sv ====
`timescale 1ns/1ns
`default_nettype none

module lock_fsm import lock_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        door_open,
    input  logic        press,
    input  logic        keypad_valid,
    input  keypad_req_t keypad_req,
    output logic        keypad_ready,
    output logic        check_valid,
    output code_t       check_code,
    input  logic        result_valid,
    input  logic        result_match,
    output logic        latch,
    output logic        beep,
    output display_t    display
);

    typedef enum logic [2:0] {
        INIT,
        LOCKED,
        CHECK_SEND,    // Entry goes to the checker
        CHECK_WAIT,
        BLOCKED,       // Keypad shut after too many failures
        UNLATCHED,     // Closed but not locked, auto-lock running
        OPEN,
        TIMEOUT_BEEP
    } lock_state_t;

    lock_state_t state;
    lock_state_t state_next;

    attempts_t attempts;
    timer_t    timer;
    code_t     req_code;
    digit_t    key0;     // Digit 0 of the keypad entry
    logic      transfer;
    logic      auto_done;
    logic      block_done;
    logic      last_try;

    digit_t [DISPLAY_DIGITS-1:0] digits;

    assign keypad_ready = (state == LOCKED);  // Back-pressure doubles as lockout
    assign transfer     = keypad_valid && keypad_ready;
    assign key0         = keypad_req.code[3:0];

    assign auto_done  = (timer == timer_t'(AUTO_LOCK_CYCLES - 1));
    assign block_done = (timer == timer_t'(BLOCK_CYCLES - 1));
    assign last_try   = (attempts == attempts_t'(MAX_ATTEMPTS - 1));

    always_comb begin
        state_next = state;
        case (state)
            INIT: begin
                if (!door_open) state_next = LOCKED;
            end
            LOCKED: begin
                if (transfer) begin
                    if (key0 == DIGIT_TIMEOUT) begin
                        state_next = TIMEOUT_BEEP;
                    end else if (key0 != DIGIT_BLANK) begin
                        state_next = CHECK_SEND;
                    end
                    // A blank entry is dropped and the lock stays put
                end else if (press) begin
                    state_next = UNLATCHED;
                end
            end
            CHECK_SEND: state_next = CHECK_WAIT;
            CHECK_WAIT: begin
                if (result_valid) begin
                    if (result_match) begin
                        state_next = UNLATCHED;
                    end else if (last_try) begin
                        state_next = BLOCKED;
                    end else begin
                        state_next = LOCKED;
                    end
                end
            end
            BLOCKED: begin
                if (block_done) state_next = LOCKED;
            end
            UNLATCHED: begin
                if (door_open) begin
                    state_next = OPEN;
                end else if (press || auto_done) begin
                    state_next = LOCKED;
                end
            end
            OPEN: begin
                if (!door_open) state_next = UNLATCHED;  // Auto-lock starts over
            end
            TIMEOUT_BEEP: state_next = LOCKED;
            default: state_next = INIT;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= INIT;
        end else begin
            state <= state_next;
        end
    end

    // Shared timer, restarted on every state change
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            timer <= '0;
        end else if (state_next != state) begin
            timer <= '0;
        end else if (state == UNLATCHED || state == BLOCKED) begin
            timer <= timer + 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            attempts <= '0;
        end else if (state == CHECK_WAIT && result_valid) begin
            attempts <= result_match ? attempts_t'(0) : attempts + 1'b1;
        end else if (state == BLOCKED && block_done) begin
            attempts <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (transfer) begin
            req_code <= keypad_req.code;
        end
    end

    assign check_valid = (state == CHECK_SEND);
    assign check_code  = req_code;

    // Beep trails TIMEOUT_BEEP by one cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            beep <= 1'b0;
        end else begin
            beep <= (state == TIMEOUT_BEEP);
        end
    end

    assign latch = (state == LOCKED)     || (state == CHECK_SEND) ||
                   (state == CHECK_WAIT) || (state == BLOCKED)    ||
                   (state == TIMEOUT_BEEP);

    // One error mark per failure, full row while blocked
    always_comb begin
        for (int i = 0; i < DISPLAY_DIGITS; i++) begin
            if (state == BLOCKED || i < attempts) begin
                digits[i] = DIGIT_ERROR;
            end else begin
                digits[i] = DIGIT_BLANK;
            end
        end
    end

    assign display = display_t'(digits);

    assert property (@(posedge clk) disable iff (rst)
        (state == BLOCKED) |-> (attempts == attempts_t'(MAX_ATTEMPTS)))
        else $error("lock_fsm: lockout without the full failure count");

endmodule

`default_nettype wire

// ==== hw/lock_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module lock_top import lock_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        door_open,      // High while the door is open
    input  logic        inside_button,
    input  logic        keypad_valid,
    input  keypad_req_t keypad_req,
    input  user_codes_t user_codes,     // From the external setup block
    output logic        keypad_ready,
    output logic        latch,          // High when the bolt is locked
    output logic        beep,
    output display_t    display
);

    logic  press;
    logic  check_valid;
    code_t check_code;
    logic  result_valid;
    logic  result_match;

    button_debouncer debouncer_i (
        .clk    (clk),
        .rst    (rst),
        .button (inside_button),
        .press  (press)
    );

    // Scans the stored slots one per cycle
    code_checker checker_i (
        .clk          (clk),
        .rst          (rst),
        .check_valid  (check_valid),
        .check_code   (check_code),
        .user_codes   (user_codes),
        .result_valid (result_valid),
        .result_match (result_match)
    );

    lock_fsm fsm_i (
        .clk          (clk),
        .rst          (rst),
        .door_open    (door_open),
        .press        (press),
        .keypad_valid (keypad_valid),
        .keypad_req   (keypad_req),
        .keypad_ready (keypad_ready),
        .check_valid  (check_valid),
        .check_code   (check_code),
        .result_valid (result_valid),
        .result_match (result_match),
        .latch        (latch),
        .beep         (beep),
        .display      (display)
    );

endmodule

`default_nettype wire

// ==== verification/lock_monitor.sv ====
`timescale 1ns/1ns
`default_nettype none

module lock_monitor import lock_pkg::*; (
    input logic        clk,
    input logic        rst,
    input logic        door_open,
    input logic        inside_button,
    input logic        keypad_valid,
    input keypad_req_t keypad_req,
    input user_codes_t user_codes,
    input logic        keypad_ready,
    input logic        latch,
    input logic        beep,
    input display_t    display
);

    event reset_test;
    event code_test;
    event wrong_test;
    event beep_test;
    event door_test;

    string name;
    int    errors;
    int    passed;
    int    failed;
    int    steps;        // Stimulus actions fully checked
    int    tests_done;
    int    cnt;
    int    low;          // Cycles with the keypad closed
    int    fails;
    int    beeps;
    int    beep_at;
    code_t entry_code;

    // Error marks fill from digit 0 upward
    function automatic display_t expected_display(input int attempts, input logic blocked);
        logic [DISPLAY_DIGITS*4-1:0] row;
        row = {DISPLAY_DIGITS{DIGIT_BLANK}};
        for (int i = 0; i < attempts && i < DISPLAY_DIGITS; i++) begin
            row[i*4 +: 4] = DIGIT_ERROR;
        end
        if (blocked) row = {DISPLAY_DIGITS{DIGIT_ERROR}};
        return display_t'(row);
    endfunction

    function automatic logic code_matches(input code_t entry, input user_codes_t codes);
        logic hit;
        hit = 1'b0;
        for (int s = 0; s < NUM_USER_CODES; s++) begin
            if (codes.slots[s] == entry && codes.slots[s] != {CODE_DIGITS{DIGIT_BLANK}}) begin
                hit = 1'b1;  // Empty slots never count
            end
        end
        return hit;
    endfunction

    task automatic start_test(input string test_name);
        name   = test_name;
        errors = 0;
    endtask

    task automatic compare_value(input string what, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERROR %s: %s expected %0h actual %0h", name, what, expected, actual);
            errors++;
        end
    endtask

    task automatic check_range(input string what, input int lo, input int hi, input int actual);
        if (actual < lo || actual > hi) begin
            $display("ERROR %s: %s expected %0d to %0d actual %0d", name, what, lo, hi, actual);
            errors++;
        end
    endtask

    task automatic problem(input string msg);
        $display("%s: %s", name, msg);
        errors++;
    endtask

    task automatic finish_test();
        if (errors == 0) begin
            passed++;
            $display("Test %s passed", name);
        end else begin
            failed++;
            $display("Test %s failed with %0d errors", name, errors);
        end
        tests_done++;
    endtask

    task automatic print_counts();
        $display("Tests passed: %0d, tests failed: %0d", passed, failed);
    endtask

    // Sampled on the rising edge, before the DUT updates
    task automatic wait_transfer(output code_t code);
        do begin
            @(posedge clk);
        end while (!(keypad_valid && keypad_ready));
        code = keypad_req.code;
    endtask

    task automatic wait_latch(input logic value, input int limit, output int cycles);
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (latch !== value && cycles < limit);
    endtask

    task automatic expect_latch_for(input logic value, input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            compare_value("latch", value, latch);
        end
    endtask

    always @(reset_test) begin
        start_test("reset_lock");
        compare_value("latch", 0, latch);
        compare_value("beep", 0, beep);
        compare_value("keypad_ready", 0, keypad_ready);
        wait (!rst);
        wait_latch(1'b1, 3, cnt);
        compare_value("latch", 1, latch);
        compare_value("keypad_ready", 1, keypad_ready);
        compare_value("display", expected_display(0, 1'b0), display);
        finish_test();
    end

    always @(code_test) begin
        start_test("correct_code");
        repeat (2) begin
            wait_transfer(entry_code);
            if (code_matches(entry_code, user_codes)) begin
                wait_latch(1'b0, 10, cnt);
                if (latch) problem("latch did not drop after a matching code");
                wait_latch(1'b1, AUTO_LOCK_CYCLES + 10, cnt);
                check_range("auto-lock delay", AUTO_LOCK_CYCLES, AUTO_LOCK_CYCLES + 2, cnt);
            end else begin
                expect_latch_for(1'b1, 10);
            end
            steps++;
        end
        finish_test();
    end

    always @(wrong_test) begin
        start_test("wrong_codes");
        fails = 0;
        repeat (MAX_ATTEMPTS) begin
            wait_transfer(entry_code);
            if (!code_matches(entry_code, user_codes)) fails++;
            low = 0;
            do begin
                @(negedge clk);
                compare_value("latch", 1, latch);
                if (!keypad_ready) begin
                    low++;
                    if (low == 10) begin
                        compare_value("display",
                                      expected_display(fails, fails >= MAX_ATTEMPTS), display);
                    end
                end
            end while (!keypad_ready && low < BLOCK_CYCLES + 20);
            if (!keypad_ready) problem("the keypad never reopened after the entry");
            if (fails >= MAX_ATTEMPTS) begin
                check_range("lockout cycles", BLOCK_CYCLES, BLOCK_CYCLES + 20, low);
                fails = 0;  // Count cleared by the lockout
            end
            compare_value("display", expected_display(fails, 1'b0), display);
            steps++;
        end
        finish_test();
    end

    always @(beep_test) begin
        start_test("timeout_beep");
        wait_transfer(entry_code);
        beeps   = 0;
        beep_at = 0;
        for (int i = 1; i <= 10; i++) begin
            @(negedge clk);
            if (beep) begin
                beeps++;
                beep_at = i;
            end
            compare_value("latch", 1, latch);
            compare_value("display", expected_display(0, 1'b0), display);
        end
        compare_value("beep cycles", 1, beeps);
        compare_value("beep delay", 2, beep_at);
        steps++;
        finish_test();
    end

    always @(door_test) begin
        start_test("button_door");
        @(negedge inside_button);  // Short hold over
        expect_latch_for(1'b1, DEBOUNCE_CYCLES + 2);
        steps++;
        @(negedge inside_button);
        wait_latch(1'b0, 8, cnt);
        if (latch) problem("latch stayed high after a long hold");
        steps++;
        @(posedge door_open);
        expect_latch_for(1'b0, 3);
        steps++;
        @(negedge door_open);
        expect_latch_for(1'b0, 3);
        steps++;
        @(posedge inside_button);
        wait_latch(1'b1, DEBOUNCE_CYCLES + 3, cnt);  // Well before the auto-lock
        if (!latch) problem("the second hold did not relock the door");
        steps++;
        finish_test();
    end

endmodule

`default_nettype wire

// ==== verification/lock_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module lock_tb import lock_pkg::*; ();

    localparam int    SEED         = 32'he2bc;
    localparam int    BLANK_SLOT   = 2;   // Slot left empty by the setup block
    localparam code_t BLANK_CODE   = {CODE_DIGITS{DIGIT_BLANK}};
    localparam int    ENTRY_BUDGET = 20;  // One keypad entry or button action
    localparam int    TEST_CYCLES  = 10
                                   + 2 * ENTRY_BUDGET + AUTO_LOCK_CYCLES
                                   + MAX_ATTEMPTS * ENTRY_BUDGET + BLOCK_CYCLES
                                   + ENTRY_BUDGET
                                   + 5 * ENTRY_BUDGET;
    localparam int    CYCLE_LIMIT  = 3 * TEST_CYCLES;

    logic        clk = 1'b0;
    logic        rst;
    logic        door_open;
    logic        inside_button;
    logic        keypad_valid;
    keypad_req_t keypad_req;
    user_codes_t user_codes;
    logic        keypad_ready;
    logic        latch;
    logic        beep;
    display_t    display;

    int    actions;  // Stimulus actions handed to the monitor
    int    cycles;
    int    pick;
    int    seed_state;
    code_t entry;

    lock_top dut_i (.*);

    lock_monitor mon_i (.*);

    always #4 clk = ~clk;

    function automatic code_t random_code();
        code_t c;
        for (int i = 0; i < CODE_DIGITS; i++) begin
            c[i*4 +: 4] = digit_t'($urandom % 10);  // Plain digits only
        end
        return c;
    endfunction

    // Blocks until the monitor has checked every action so far
    task automatic sync_monitor();
        actions++;
        wait (mon_i.steps == actions);
    endtask

    task automatic enter_code(input code_t code);
        @(negedge clk);
        keypad_valid    = 1'b1;
        keypad_req.code = code;
        do begin
            @(posedge clk);
        end while (!keypad_ready);
        @(negedge clk);
        keypad_valid = 1'b0;
        sync_monitor();
    endtask

    task automatic hold_button(input int cycles_held);
        @(negedge clk);
        inside_button = 1'b1;
        repeat (cycles_held) @(negedge clk);
        inside_button = 1'b0;
        sync_monitor();
    endtask

    task automatic set_door(input logic is_open);
        @(negedge clk);
        door_open = is_open;
        sync_monitor();
    endtask

    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, the tests did not complete", CYCLE_LIMIT);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        seed_state    = SEED;
        void'($urandom(seed_state));
        rst           = 1'b1;
        door_open     = 1'b0;
        inside_button = 1'b0;
        keypad_valid  = 1'b0;
        keypad_req    = '0;
        for (int i = 0; i < NUM_USER_CODES; i++) begin
            user_codes.slots[i] = random_code();
        end
        user_codes.slots[BLANK_SLOT] = BLANK_CODE;
        @(negedge clk);
        -> mon_i.reset_test;
        @(negedge clk);
        rst = 1'b0;
        wait (mon_i.tests_done == 1);

        -> mon_i.code_test;
        enter_code(BLANK_CODE);
        pick = $urandom % (NUM_USER_CODES - 1);
        if (pick >= BLANK_SLOT) pick++;
        enter_code(user_codes.slots[pick]);
        wait (mon_i.tests_done == 2);

        -> mon_i.wrong_test;
        repeat (MAX_ATTEMPTS) begin
            do begin
                entry = random_code();
            end while (mon_i.code_matches(entry, user_codes));
            enter_code(entry);
        end
        wait (mon_i.tests_done == 3);

        -> mon_i.beep_test;
        entry      = random_code();
        entry[3:0] = DIGIT_TIMEOUT;
        enter_code(entry);
        wait (mon_i.tests_done == 4);

        -> mon_i.door_test;
        hold_button(DEBOUNCE_CYCLES - 1);  // Too short to count
        hold_button(DEBOUNCE_CYCLES + 2);
        set_door(1'b1);
        set_door(1'b0);
        hold_button(DEBOUNCE_CYCLES + 2);
        wait (mon_i.tests_done == 5);

        mon_i.print_counts();
        if (mon_i.failed == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
hw/lock_pkg.sv
hw/button_debouncer.sv
hw/code_checker.sv
hw/lock_fsm.sv
hw/lock_top.sv
verification/lock_monitor.sv
verification/lock_tb.sv

// ==== Bender.yml ====
package:
  name: keypad_lock

sources:
  # Synthesizable design
  - files:
      - hw/lock_pkg.sv
      - hw/button_debouncer.sv
      - hw/code_checker.sv
      - hw/lock_fsm.sv
      - hw/lock_top.sv
  # Testbench sources
  - target: test
    files:
      - verification/lock_monitor.sv
      - verification/lock_tb.sv
